// ==== verilog/hub75_consts.svh ====
`ifndef HUB75_CONSTS_SVH
`define HUB75_CONSTS_SVH

// panel geometry
// columns shifted per row
`define HUB75_WIDTH 64

// rows per half, scanned as top/bottom pairs
`define HUB75_HALF_HEIGHT 16

// colour depth
// bits per channel, one bit plane each
`define HUB75_DEPTH 6

// enable timing
// plane 0 window in clk_in cycles
// plane p is lit for base << p cycles
`define HUB75_OE_BASE 4

// datapath alignment
// scan address to panel pins, in cycles
// one for the store read, one for the output registers
`define HUB75_READ_LATENCY 2

`endif

// ==== verilog/hub75_pkg.sv ====
`include "hub75_consts.svh"

package hub75_pkg;

    // one colour value, one bit per plane
    typedef logic [`HUB75_DEPTH-1:0] channel_t;

    // channel slots inside a pixel, red on top
    localparam int CH_RED = 2;
    localparam int CH_GREEN = 1;
    localparam int CH_BLUE = 0;

    // 18 bit pixel as three channels
    typedef channel_t [2:0] pixel_t;

    // column index, 0..63
    typedef logic [$clog2(`HUB75_WIDTH)-1:0] column_t;

    // row pair index, 0..15
    typedef logic [$clog2(`HUB75_HALF_HEIGHT)-1:0] row_t;

    // bit plane index, 0..5
    typedef logic [$clog2(`HUB75_DEPTH)-1:0] plane_t;

    // full panel row as the host sees it
    // msb picks the bottom bank
    typedef logic [$clog2(2 * `HUB75_HALF_HEIGHT)-1:0] write_row_t;

endpackage

// ==== verilog/matrix_scan.sv ====
`timescale 1ns/1ps
`include "hub75_consts.svh"

module matrix_scan (
    input  logic               clk_in,
    input  logic               reset,
    // column being shifted, 63 down to 0
    output hub75_pkg::column_t column_address,
    // row pair being shifted
    output hub75_pkg::row_t    scan_row,
    // row pair on display after the last latch
    output hub75_pkg::row_t    display_row,
    // bit plane being shifted
    output hub75_pkg::plane_t  plane,
    output logic               shift_strobe,
    output logic               latch_strobe,
    output logic               oe_active
);
    import hub75_pkg::*;

    // two cycles per column
    localparam int SHIFT_CYCLES = 2 * `HUB75_WIDTH;
    localparam int SHIFT_W = $clog2(SHIFT_CYCLES + 1);

    // longest window is the msb plane
    localparam int OE_MAX = `HUB75_OE_BASE << (`HUB75_DEPTH - 1);
    localparam int OE_W = $clog2(OE_MAX + 1);

    localparam plane_t TOP_PLANE = plane_t'(`HUB75_DEPTH - 1);

    // cycles into the current shift
    // parks at SHIFT_CYCLES once all columns are out
    logic [SHIFT_W-1:0] shift_cnt;

    // cycles left in the enable window
    logic [OE_W-1:0] oe_cnt;

    logic shifting;
    logic [OE_W-1:0] oe_window;

    assign shifting = shift_cnt < SHIFT_W'(SHIFT_CYCLES);

    // strobe on the first cycle of each column pair
    assign shift_strobe = shifting && !shift_cnt[0];

    // count up, columns go out high to low
    // inverting the pair index gives 63 - n
    assign column_address = ~column_t'(shift_cnt >> 1);

    // latch waits for both the shift and the old window
    // with the longest window at 128 this is always cycle 128
    assign latch_strobe = !shifting && (oe_cnt == '0);

    assign oe_active = (oe_cnt != '0);

    // binary weighted window for the plane being latched
    assign oe_window = OE_W'(`HUB75_OE_BASE) << plane;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            shift_cnt <= '0;
            oe_cnt <= '0;
        end else if (latch_strobe) begin
            // next shift overlaps the window just opened
            shift_cnt <= '0;
            oe_cnt <= oe_window;
        end else begin
            if (shifting) begin
                shift_cnt <= shift_cnt + 1'b1;
            end
            if (oe_active) begin
                oe_cnt <= oe_cnt - 1'b1;
            end
        end
    end

    // plane and row walk, msb plane first
    always_ff @(posedge clk_in) begin
        if (reset) begin
            plane <= TOP_PLANE;
            scan_row <= '0;
            display_row <= '0;
        end else if (latch_strobe) begin
            // the row just shifted goes on display
            display_row <= scan_row;
            if (plane == '0) begin
                // last plane done, move to next pair
                // 4 bit row wraps 15 -> 0 on its own
                plane <= TOP_PLANE;
                scan_row <= scan_row + 1'b1;
            end else begin
                plane <= plane - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/frame_store.sv ====
`timescale 1ns/1ps
`include "hub75_consts.svh"

module frame_store (
    input  logic                   clk_in,
    // host write port, one pixel per strobe
    input  logic                   wr_en,
    input  hub75_pkg::write_row_t  wr_row,
    input  hub75_pkg::column_t     wr_column,
    input  hub75_pkg::pixel_t      wr_data,
    // scan read port, same address into both banks
    input  hub75_pkg::row_t        rd_row,
    input  hub75_pkg::column_t     rd_column,
    output hub75_pkg::pixel_t      top_pixel,
    output hub75_pkg::pixel_t      bottom_pixel
);
    import hub75_pkg::*;

    // one bank per panel half
    localparam int BANK_WORDS = `HUB75_HALF_HEIGHT * `HUB75_WIDTH;
    localparam int ADDR_W = $bits(row_t) + $bits(column_t);

    pixel_t mem_top [BANK_WORDS];
    pixel_t mem_bottom [BANK_WORDS];

    logic wr_bank;
    row_t wr_half_row;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // rows 16..31 go to the bottom bank
    assign wr_bank = wr_row[$bits(write_row_t)-1];
    assign wr_half_row = wr_row[$bits(row_t)-1:0];

    // row major, column in the low bits
    assign wr_addr = {wr_half_row, wr_column};
    assign rd_addr = {rd_row, rd_column};

    // host writes land any time, reset included
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_bank) begin
                mem_bottom[wr_addr] <= wr_data;
            end else begin
                mem_top[wr_addr] <= wr_data;
            end
        end
    end

    // registered read, one cycle behind the address
    // a write is seen from the following cycle on
    always_ff @(posedge clk_in) begin
        top_pixel <= mem_top[rd_addr];
        bottom_pixel <= mem_bottom[rd_addr];
    end

endmodule

// ==== verilog/bit_plane_mux.sv ====
`timescale 1ns/1ps
`include "hub75_consts.svh"

module bit_plane_mux (
    input  logic              clk_in,
    input  logic              reset,
    input  hub75_pkg::pixel_t top_pixel,
    input  hub75_pkg::pixel_t bottom_pixel,
    input  hub75_pkg::plane_t plane,
    input  logic              shift_strobe,
    input  logic              latch_strobe,
    input  logic              oe_active,
    input  hub75_pkg::row_t   display_row,
    output logic              r0,
    output logic              g0,
    output logic              b0,
    output logic              r1,
    output logic              g1,
    output logic              b1,
    output logic              panel_clk,
    output logic              lat,
    output logic              oe_n,
    output hub75_pkg::row_t   row_address
);
    import hub75_pkg::*;

    // stages to line scan timing up with the store read
    localparam int STAGES = `HUB75_READ_LATENCY - 1;

    // shift gets one extra stage, panel_clk lands on the second cycle
    logic [STAGES:0] shift_pipe;
    logic [STAGES-1:0] latch_pipe;
    logic [STAGES-1:0] oe_pipe;
    plane_t plane_pipe [STAGES];

    logic shift_aligned;
    logic latch_aligned;
    logic oe_aligned;
    plane_t plane_aligned;

    assign shift_aligned = shift_pipe[STAGES-1];
    assign latch_aligned = latch_pipe[STAGES-1];
    assign oe_aligned = oe_pipe[STAGES-1];
    assign plane_aligned = plane_pipe[STAGES-1];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            shift_pipe <= '0;
            latch_pipe <= '0;
            oe_pipe <= '0;
        end else begin
            shift_pipe[0] <= shift_strobe;
            latch_pipe[0] <= latch_strobe;
            oe_pipe[0] <= oe_active;
            for (int i = 1; i < STAGES; i++) begin
                latch_pipe[i] <= latch_pipe[i-1];
                oe_pipe[i] <= oe_pipe[i-1];
            end
            for (int i = 1; i <= STAGES; i++) begin
                shift_pipe[i] <= shift_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        plane_pipe[0] <= plane;
        for (int i = 1; i < STAGES; i++) begin
            plane_pipe[i] <= plane_pipe[i-1];
        end
    end

    // pick the plane bit, held over both cycles of the column
    always_ff @(posedge clk_in) begin
        if (shift_aligned) begin
            r0 <= top_pixel[CH_RED][plane_aligned];
            g0 <= top_pixel[CH_GREEN][plane_aligned];
            b0 <= top_pixel[CH_BLUE][plane_aligned];
            r1 <= bottom_pixel[CH_RED][plane_aligned];
            g1 <= bottom_pixel[CH_GREEN][plane_aligned];
            b1 <= bottom_pixel[CH_BLUE][plane_aligned];
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            lat <= 1'b0;
            panel_clk <= 1'b0;
            oe_n <= 1'b1;
            row_address <= '0;
        end else begin
            lat <= latch_aligned;
            // rising edge mid column, data already stable
            panel_clk <= shift_pipe[STAGES];
            // LEDs dark while the latch is open
            oe_n <= !oe_aligned || latch_aligned;
            // display_row already trails the latch by a cycle
            if (latch_aligned) begin
                row_address <= display_row;
            end
        end
    end

endmodule

// ==== verilog/hub75_top.sv ====
`timescale 1ns/1ps

module hub75_top (
    input  logic                  clk_in,
    input  logic                  reset,
    // host pixel writes
    input  logic                  wr_en,
    input  hub75_pkg::write_row_t wr_row,
    input  hub75_pkg::column_t    wr_column,
    input  hub75_pkg::pixel_t     wr_data,
    // HUB75 panel pins
    output logic                  r0,
    output logic                  g0,
    output logic                  b0,
    output logic                  r1,
    output logic                  g1,
    output logic                  b1,
    output logic                  panel_clk,
    output logic                  lat,
    output logic                  oe_n,
    output hub75_pkg::row_t       row_address
);
    import hub75_pkg::*;

    // scan to store
    column_t column_address;
    row_t scan_row;

    // store to mux, one cycle after the address
    pixel_t top_pixel;
    pixel_t bottom_pixel;

    // scan to mux, not yet aligned
    row_t display_row;
    plane_t plane;
    logic shift_strobe;
    logic latch_strobe;
    logic oe_active;

    matrix_scan u_scan (
        .clk_in         (clk_in),
        .reset          (reset),
        .column_address (column_address),
        .scan_row       (scan_row),
        .display_row    (display_row),
        .plane          (plane),
        .shift_strobe   (shift_strobe),
        .latch_strobe   (latch_strobe),
        .oe_active      (oe_active)
    );

    frame_store u_store (
        .clk_in       (clk_in),
        .wr_en        (wr_en),
        .wr_row       (wr_row),
        .wr_column    (wr_column),
        .wr_data      (wr_data),
        .rd_row       (scan_row),
        .rd_column    (column_address),
        .top_pixel    (top_pixel),
        .bottom_pixel (bottom_pixel)
    );

    bit_plane_mux u_mux (
        .clk_in       (clk_in),
        .reset        (reset),
        .top_pixel    (top_pixel),
        .bottom_pixel (bottom_pixel),
        .plane        (plane),
        .shift_strobe (shift_strobe),
        .latch_strobe (latch_strobe),
        .oe_active    (oe_active),
        .display_row  (display_row),
        .r0           (r0),
        .g0           (g0),
        .b0           (b0),
        .r1           (r1),
        .g1           (g1),
        .b1           (b1),
        .panel_clk    (panel_clk),
        .lat          (lat),
        .oe_n         (oe_n),
        .row_address  (row_address)
    );

endmodule

// ==== sim/hub75_properties.sv ====
`timescale 1ns/1ps

module hub75_properties (
    input logic            clk_in,
    input logic            reset,
    input logic            lat,
    input logic            oe_n,
    input logic            panel_clk,
    input hub75_pkg::row_t row_address
);
    // failed assertions so far
    int unsigned fail_count = 0;

    // LEDs stay dark while the latch is open
    assert property (@(posedge clk_in) disable iff (reset) lat |-> oe_n)
        else begin
            $error("oe_n low during lat");
            fail_count++;
        end

    // no shift clock while latching
    assert property (@(posedge clk_in) disable iff (reset) !(panel_clk && lat))
        else begin
            $error("panel_clk high together with lat");
            fail_count++;
        end

    // row lines only move with the latch
    assert property (@(posedge clk_in) disable iff (reset) !$stable(row_address) |-> lat)
        else begin
            $error("row_address changed without lat");
            fail_count++;
        end

endmodule

bind hub75_top hub75_properties u_properties (
    .clk_in      (clk_in),
    .reset       (reset),
    .lat         (lat),
    .oe_n        (oe_n),
    .panel_clk   (panel_clk),
    .row_address (row_address)
);

// ==== sim/hub75_tb.sv ====
`timescale 1ns/1ps
`include "hub75_consts.svh"

module hub75_tb;
    import hub75_pkg::*;

    // one frame of lat periods, 129 cycles each
    localparam int FRAME_CYCLES = `HUB75_HALF_HEIGHT * `HUB75_DEPTH * (2 * `HUB75_WIDTH + 1);
    localparam int CYCLE_LIMIT = 3 * FRAME_CYCLES + 2 * `HUB75_HALF_HEIGHT * `HUB75_WIDTH + 1000;

    logic clk_in = 1'b0;
    logic reset;
    logic wr_en;
    write_row_t wr_row;
    column_t wr_column;
    pixel_t wr_data;
    logic r0, g0, b0, r1, g1, b1;
    logic panel_clk;
    logic lat;
    logic oe_n;
    row_t row_address;

    // frame model, full rows 0..31
    logic [17:0] model [32][64];
    // kind, row, column, data per word
    logic [39:0] testdata [64];
    logic [39:0] first_writes [$];
    logic [39:0] update_writes [$];

    int cycles = 0;
    int since_lat = 0;
    int edges = 0;
    int frames = 0;
    int oe_window = 0;
    int shift_row = 0;
    int shift_plane = `HUB75_DEPTH - 1;
    logic started = 1'b0;
    logic checking = 1'b0;
    logic update_go = 1'b0;
    logic done = 1'b0;

    hub75_top u_dut (.*);

    always #20 clk_in = ~clk_in;

    task automatic fail_run(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s expected 0x%h, got 0x%h", name, expected, actual));
        end
    endtask

    // one host write, model follows the DUT
    task automatic write_pixel(logic [39:0] w);
        @(posedge clk_in);
        wr_en <= 1'b1;
        wr_row <= w[32:28];
        wr_column <= w[25:20];
        wr_data <= w[17:0];
        model[w[32:28]][w[25:20]] = w[17:0];
    endtask

    // plane bit of both halves, red in the top channel
    function automatic logic [5:0] plane_bits(int row, int plane, int col);
        logic [17:0] top;
        logic [17:0] bot;
        top = model[row][col];
        bot = model[row + 16][col];
        return {top[12 + plane], top[6 + plane], top[plane],
                bot[12 + plane], bot[6 + plane], bot[plane]};
    endfunction

    initial begin
        int section;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_row = '0;
        wr_column = '0;
        wr_data = '0;
        void'($urandom(32'h547f));
        foreach (model[r, c]) model[r][c] = 18'($urandom);
        $readmemh("sim/hub75_testdata.txt", testdata);
        section = 0;
        for (int i = 0; i < 64; i++) begin
            if (testdata[i][39:36] === 4'hF) break;
            if (i == 63 || $isunknown(testdata[i])) fail_run("testdata has no end marker");
            if (testdata[i][39:36] == 4'hA) section = 1;
            else if (testdata[i][39:36] == 4'hB) section = 2;
            else if (section == 1) first_writes.push_back(testdata[i]);
            else update_writes.push_back(testdata[i]);
        end
        // pair 0 is being read when the update starts
        foreach (update_writes[i]) begin
            if (update_writes[i][31:28] == 4'h0) fail_run("update section writes row pair 0");
        end
        fork
            begin
                foreach (model[r, c]) write_pixel({4'h1, 8'(r), 8'(c), 2'b0, model[r][c]});
                foreach (first_writes[i]) write_pixel(first_writes[i]);
                @(posedge clk_in) wr_en <= 1'b0;
                wait (update_go);
                foreach (update_writes[i]) write_pixel(update_writes[i]);
                @(posedge clk_in) wr_en <= 1'b0;
            end
            begin
                repeat (2) @(posedge clk_in);
                reset <= 1'b0;
            end
            // idle outputs in reset and the cycle after
            repeat (3) begin
                @(negedge clk_in);
                check_value("lat", 0, lat);
                check_value("panel_clk", 0, panel_clk);
                check_value("oe_n", 1, oe_n);
            end
        join_none
        wait (done);
        $display(">>> PASS");
        $finish;
    end

    // panel side, sampled mid cycle
    always @(negedge clk_in) begin
        if (u_dut.u_properties.fail_count != 0) fail_run("panel protocol assertion failed");
        if (!reset) begin
            cycles++;
            since_lat++;
            if (cycles > CYCLE_LIMIT) fail_run("timeout, three frames of lat pulses not seen");
            if (lat) begin
                check_value("oe_n", 1, oe_n);
                check_value("panel_clk edges", 64, edges);
                check_value("row_address", shift_row, row_address);
                if (started) check_value("lat spacing", 129, since_lat);
                started = 1'b1;
                since_lat = 0;
                edges = 0;
                oe_window = `HUB75_OE_BASE << shift_plane;
                if (shift_plane == 0) begin
                    shift_plane = `HUB75_DEPTH - 1;
                    shift_row = (shift_row + 1) % `HUB75_HALF_HEIGHT;
                end else begin
                    shift_plane--;
                end
                // new frame starts at row 0, top plane
                if (shift_row == 0 && shift_plane == `HUB75_DEPTH - 1) begin
                    frames++;
                    checking = (frames < 3);
                    if (frames == 1) update_go = 1'b1;
                    if (frames == 3) done = 1'b1;
                end
            end else begin
                check_value("oe_n", !started || since_lat > oe_window, oe_n);
            end
            if (panel_clk) begin
                if (edges >= `HUB75_WIDTH) fail_run("more than 64 panel_clk edges in one shift");
                if (checking) begin
                    check_value("rgb", plane_bits(shift_row, shift_plane, 63 - edges),
                                {r0, g0, b0, r1, g1, b1});
                end
                edges++;
            end
        end
    end

endmodule

// ==== sim/hub75_testdata.txt ====
// kind(1) row(2) column(2) data(5): kind 1 is a write, A and B open sections, F ends
// row 0..31, column 0..63, data is {red, green, blue} with 6 bits each
A000000000
100003FFFF
1103F00000
1052015555
11F012AAAA
10A3E0003F
B000000000
1013F3F000
1110000FC0
1071A3FFFF
1171A00000
10F0015A5A
11F3F2C3C3
F000000000

// ==== sources.f ====
+incdir+verilog
verilog/hub75_pkg.sv
verilog/matrix_scan.sv
verilog/frame_store.sv
verilog/bit_plane_mux.sv
verilog/hub75_top.sv
sim/hub75_properties.sv
sim/hub75_tb.sv

// ==== Bender.yml ====
package:
  name: hub75

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/hub75_pkg.sv
      - verilog/matrix_scan.sv
      - verilog/frame_store.sv
      - verilog/bit_plane_mux.sv
      - verilog/hub75_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/hub75_properties.sv
      - sim/hub75_tb.sv
